/* compile.f */
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_wb_regs.sv
src/uart_top.sv
tb/tb_uart_top.sv

/* src/uart_pkg.sv */
package uart_pkg;

   // ********************
   // Widths on the line and on the bus.
   // ********************

   // One character on the serial line.
   typedef logic [7:0] byte_t;

   // Host command, sent as two characters.
   typedef logic [15:0] cmd_t;

   // Wishbone data word.
   typedef logic [15:0] wb_data_t;

   // Register index on the bus.
   typedef logic [1:0] reg_addr_t;

   // ********************
   // Register map.
   // ********************

   localparam reg_addr_t addr_tx_cmd  = 2'd0;  // Command launch, last command on read.
   localparam reg_addr_t addr_status  = 2'd1;  // Busy and receive flags.
   localparam reg_addr_t addr_rx_data = 2'd2;  // Last received byte.

   // ********************
   // Serial frame.
   // ********************

   // Start, eight data bits, odd parity, stop.
   localparam int frame_bits = 11;

endpackage

/* src/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
   parameter int clks_per_bit = 16
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            rx,
   output uart_pkg::byte_t rx_byte,
   output logic            rx_strobe,
   output logic            parity_err,
   output logic            frame_err
);

   import uart_pkg::*;

   // Frame minus start, parity and stop.
   localparam int data_bits = frame_bits - 3;
   localparam int cnt_w     = $clog2(clks_per_bit);
   localparam int idx_w     = $clog2(data_bits);

   localparam logic [cnt_w-1:0] cnt_last  = cnt_w'(clks_per_bit - 1);
   localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);
   localparam logic [idx_w-1:0] idx_last  = idx_w'(data_bits - 1);

   typedef enum logic [2:0] {
      st_idle,
      st_start,
      st_data,
      st_parity,
      st_stop
   } state_t;

   state_t            state;
   logic              rx_meta;
   logic              rx_sync;
   logic              rx_last;
   logic [cnt_w-1:0]  clk_cnt;
   logic [idx_w-1:0]  bit_idx;
   byte_t             data_q;
   logic              par_q;
   logic              tick;
   logic              fall;

   // ********************
   // Input synchronizer.
   // ********************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_last <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_last <= rx_sync;
      end
   end

   assign fall    = rx_last && !rx_sync;
   assign tick    = (clk_cnt == cnt_last);   // Middle of a bit after the start check.
   assign rx_byte = data_q;

   // Data and parity samples.
   always_ff @(posedge clk) begin
      if (tick && state == st_data) begin
         data_q <= {rx_sync, data_q[data_bits-1:1]};   // LSB arrives first.
      end
      if (tick && state == st_parity) begin
         par_q <= rx_sync;
      end
   end

   // ********************
   // Frame FSM.
   // ********************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= st_idle;
         clk_cnt    <= '0;
         bit_idx    <= '0;
         rx_strobe  <= 1'b0;
         parity_err <= 1'b0;
         frame_err  <= 1'b0;
      end else begin
         rx_strobe <= 1'b0;
         case (state)
            st_idle: begin
               clk_cnt <= '0;
               if (fall) begin
                  state <= st_start;
               end
            end

            st_start: begin
               if (clk_cnt == half_last) begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  // High again at mid start means a glitch.
                  state   <= rx_sync ? st_idle : st_data;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            st_data: begin
               if (tick) begin
                  clk_cnt <= '0;
                  if (bit_idx == idx_last) begin
                     state <= st_parity;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            st_parity: begin
               if (tick) begin
                  clk_cnt <= '0;
                  state   <= st_stop;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            st_stop: begin
               if (tick) begin
                  // Data plus parity must hold an odd count of ones.
                  parity_err <= ~^{data_q, par_q};
                  frame_err  <= ~rx_sync;
                  rx_strobe  <= 1'b1;
                  state      <= st_idle;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

/* src/uart_top.sv */
`timescale 1ns/10ps

module uart_top #(
   parameter int clks_per_bit = 16
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  uart_pkg::reg_addr_t wb_adr,
   input  uart_pkg::wb_data_t  wb_dat_w,
   output uart_pkg::wb_data_t  wb_dat_r,
   output logic                wb_ack,
   input  logic                rx,
   output logic                tx
);

   import uart_pkg::*;

   cmd_t   cmd;
   logic   cmd_valid;
   logic   cmd_ready;
   byte_t  rx_byte;
   logic   rx_strobe;
   logic   parity_err;
   logic   frame_err;

   // Host side.
   uart_wb_regs u_regs (
      .clk        (clk),
      .rst_n      (rst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .cmd        (cmd),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .rx_byte    (rx_byte),
      .rx_strobe  (rx_strobe),
      .parity_err (parity_err),
      .frame_err  (frame_err)
   );

   uart_tx #(
      .clks_per_bit (clks_per_bit)
   ) u_tx (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .tx        (tx)
   );

   uart_rx #(
      .clks_per_bit (clks_per_bit)
   ) u_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .rx_byte    (rx_byte),
      .rx_strobe  (rx_strobe),
      .parity_err (parity_err),
      .frame_err  (frame_err)
   );

endmodule

/* src/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
   parameter int clks_per_bit = 16
) (
   input  logic           clk,
   input  logic           rst_n,
   input  uart_pkg::cmd_t cmd,
   input  logic           cmd_valid,
   output logic           cmd_ready,
   output logic           tx
);

   import uart_pkg::*;

   // Both frames of a command go out back to back.
   localparam int total_bits = 2 * frame_bits;
   localparam int cnt_w      = $clog2(clks_per_bit);
   localparam int bit_w      = $clog2(total_bits + 1);

   localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
   localparam logic [bit_w-1:0] bit_last = bit_w'(total_bits);

   typedef enum logic {
      st_idle,
      st_shift
   } state_t;

   state_t                  state;
   logic [cnt_w-1:0]        clk_cnt;
   logic [bit_w-1:0]        bit_cnt;
   logic [total_bits-1:0]   shift_q;
   logic                    tick;
   logic                    accept;

   // One frame, LSB of the vector goes out first.
   function automatic logic [frame_bits-1:0] make_frame(input byte_t data);
      return {1'b1, ~^data, data, 1'b0};
   endfunction

   assign cmd_ready = (state == st_idle);
   assign accept    = cmd_ready && cmd_valid;
   assign tick      = (clk_cnt == cnt_last);

   // ********************
   // Frame shift register.
   // ********************

   always_ff @(posedge clk) begin
      if (accept) begin
         // High byte sits in the low bits so it leaves first.
         shift_q <= {make_frame(cmd[7:0]), make_frame(cmd[15:8])};
      end else if (state == st_shift && tick && bit_cnt != bit_last) begin
         shift_q <= {1'b1, shift_q[total_bits-1:1]};
      end
   end

   // ********************
   // Bit timing and line driver.
   // ********************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= st_idle;
         clk_cnt <= '0;
         bit_cnt <= '0;
         tx      <= 1'b1;   // Line idles high.
      end else begin
         case (state)
            st_idle: begin
               if (accept) begin
                  // First tick on the next edge puts the start bit out.
                  clk_cnt <= cnt_last;
                  bit_cnt <= '0;
                  state   <= st_shift;
               end
            end

            st_shift: begin
               if (tick) begin
                  clk_cnt <= '0;
                  if (bit_cnt == bit_last) begin
                     // Last stop bit has had its full period.
                     tx    <= 1'b1;
                     state <= st_idle;
                  end else begin
                     tx      <= shift_q[0];
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end

            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

/* src/uart_wb_regs.sv */
`timescale 1ns/10ps

module uart_wb_regs (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                wb_cyc,
   input  logic                wb_stb,
   input  logic                wb_we,
   input  uart_pkg::reg_addr_t wb_adr,
   input  uart_pkg::wb_data_t  wb_dat_w,
   output uart_pkg::wb_data_t  wb_dat_r,
   output logic                wb_ack,
   output uart_pkg::cmd_t      cmd,
   output logic                cmd_valid,
   input  logic                cmd_ready,
   input  uart_pkg::byte_t     rx_byte,
   input  logic                rx_strobe,
   input  logic                parity_err,
   input  logic                frame_err
);

   import uart_pkg::*;

   logic      pending;
   logic      wr_cmd;
   logic      rd_rx;
   logic      ack_next;
   logic      tx_busy;
   cmd_t      cmd_q;
   byte_t     rx_data_q;
   logic      rx_valid;
   logic      overrun;
   logic      parity_flag;
   logic      frame_flag;
   wb_data_t  status;
   wb_data_t  rd_mux;

   // ********************
   // Bus decode.
   // ********************

   // Masked by ack so one access gives one acknowledge.
   assign pending = wb_cyc && wb_stb && !wb_ack;
   assign wr_cmd  = pending && wb_we && (wb_adr == addr_tx_cmd);
   assign rd_rx   = pending && !wb_we && (wb_adr == addr_rx_data);

   // Command writes stall until the transmitter takes them.
   assign ack_next = pending && (!wr_cmd || cmd_ready);

   // Master holds the data steady until acknowledged.
   assign cmd       = wb_dat_w;
   assign cmd_valid = wr_cmd;

   assign tx_busy = ~cmd_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= ack_next;
      end
   end

   // Last launched command, for read back.
   always_ff @(posedge clk) begin
      if (wr_cmd && cmd_ready) begin
         cmd_q <= wb_dat_w;
      end
   end

   // ********************
   // Receive byte and flags.
   // ********************

   always_ff @(posedge clk) begin
      if (rx_strobe) begin
         rx_data_q <= rx_byte;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_valid    <= 1'b0;
         overrun     <= 1'b0;
         parity_flag <= 1'b0;
         frame_flag  <= 1'b0;
      end else if (rx_strobe) begin
         // New byte beats a read in the same cycle.
         rx_valid    <= 1'b1;
         overrun     <= (overrun || rx_valid) && !rd_rx;
         parity_flag <= (parity_flag && !rd_rx) || parity_err;
         frame_flag  <= (frame_flag && !rd_rx) || frame_err;
      end else if (rd_rx) begin
         rx_valid    <= 1'b0;
         overrun     <= 1'b0;
         parity_flag <= 1'b0;
         frame_flag  <= 1'b0;
      end
   end

   // ********************
   // Read data.
   // ********************

   assign status = {11'b0, overrun, frame_flag, parity_flag, rx_valid, tx_busy};

   always_comb begin
      case (wb_adr)
         addr_tx_cmd:  rd_mux = cmd_q;
         addr_status:  rd_mux = status;
         addr_rx_data: rd_mux = {8'b0, rx_data_q};
         default:      rd_mux = '0;
      endcase
   end

   // Captured with the acknowledge.
   always_ff @(posedge clk) begin
      if (ack_next) begin
         wb_dat_r <= rd_mux;
      end
   end

endmodule

/* tb/tb_uart_top.sv */
`timescale 1ns/10ps

module tb_uart_top;

   import uart_pkg::*;

   localparam int cpb        = 8;
   localparam int clk_period = 8;
   localparam int bus_limit  = 400;   // Long enough for a full command stall.
   localparam int poll_limit = 50;

   logic        clk;
   logic        rst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   reg_addr_t   wb_adr;
   wb_data_t    wb_dat_w;
   wb_data_t    wb_dat_r;
   logic        wb_ack;
   logic        rx;
   logic        tx;
   logic [31:0] rng_state;
   int          error_count;
   int          test_count;
   int          fail_count;

   uart_top #(.clks_per_bit(cpb)) uut (
      .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .rx(rx), .tx(tx)
   );

   always #(clk_period / 2) clk = ~clk;

   // ********************
   // Helpers.
   // ********************

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Bit that makes the ones in data plus parity odd.
   function automatic logic parity_bit(input byte_t b);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) ones += b[i];
      return (ones % 2 == 0);
   endfunction

   task automatic report_mismatch(input string sig, input logic [15:0] exp, input logic [15:0] act);
      $display("MISMATCH at %0t ns: %s expected %h got %h", $time, sig, exp, act);
      error_count++;
   endtask

   task automatic report_error(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      error_count++;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      test_count++;
      if (error_count == errs_before) begin
         $display("%s: ok", name);
      end else begin
         fail_count++;
         $display("%s: FAILED with %0d errors", name, error_count - errs_before);
      end
   endtask

   // Lands 1 ns after a rising edge.
   task automatic step_clocks(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // ********************
   // Bus and serial tasks.
   // ********************

   task automatic wb_write(input reg_addr_t adr, input wb_data_t data, output time ack_time);
      int n;
      step_clocks(1);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = data;
      n = 0;
      do begin
         step_clocks(1);
         n++;
      end while (wb_ack !== 1'b1 && n < bus_limit);
      ack_time = $time;
      if (wb_ack !== 1'b1) report_error("write got no wb_ack");
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_read(input reg_addr_t adr, output wb_data_t data);
      int n;
      step_clocks(1);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      n = 0;
      do begin
         step_clocks(1);
         n++;
      end while (wb_ack !== 1'b1 && n < bus_limit);
      data = wb_dat_r;
      if (wb_ack !== 1'b1) report_error("read got no wb_ack");
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic send_frame(input byte_t data, input logic par, input logic stop);
      logic [frame_bits-1:0] bits;
      bits = {stop, par, data, 1'b0};
      step_clocks(1);
      for (int i = 0; i < frame_bits; i++) begin
         rx = bits[i];
         step_clocks(cpb);
      end
      rx = 1'b1;
      step_clocks(cpb);   // One idle bit.
   endtask

   task automatic capture_frame(output byte_t data, output logic par, output logic stop,
                                output time stop_time);
      int n;
      data      = 'x;
      par       = 1'bx;
      stop      = 1'bx;
      stop_time = 0;
      n = 0;
      while (tx !== 1'b0 && n < 40 * cpb) begin
         step_clocks(1);
         n++;
      end
      if (tx !== 1'b0) begin
         report_error("no start bit on tx");
      end else begin
         step_clocks(cpb / 2);   // Middle of the start bit.
         if (tx !== 1'b0) report_mismatch("tx start bit", 16'h0, tx);
         for (int i = 0; i < 8; i++) begin
            step_clocks(cpb);
            data[i] = tx;
         end
         step_clocks(cpb);
         par = tx;
         step_clocks(cpb);
         stop      = tx;
         stop_time = $time;
      end
   endtask

   // High byte first, then low byte.
   task automatic capture_command(input cmd_t exp, output time stop_time);
      byte_t data;
      byte_t want;
      logic  par;
      logic  stop;
      for (int f = 0; f < 2; f++) begin
         want = (f == 0) ? exp[15:8] : exp[7:0];
         capture_frame(data, par, stop, stop_time);
         if (data !== want) report_mismatch("tx data", want, data);
         if (par !== parity_bit(want)) report_mismatch("tx parity", parity_bit(want), par);
         if (stop !== 1'b1) report_mismatch("tx stop bit", 16'h1, stop);
      end
   endtask

   // Start bit one cycle after the handshake edge, then both frames back to back.
   task automatic check_command_timing(input time ack_time, input time stop_time);
      time want;
      want = (1 + cpb / 2 + (2 * frame_bits - 1) * cpb) * clk_period;
      if (stop_time - ack_time != want) begin
         report_error("command frames not timed from the handshake edge");
      end
   endtask

   task automatic wait_tx_idle;
      wb_data_t st;
      int       n;
      n = 0;
      wb_read(addr_status, st);
      while (st[0] !== 1'b0 && n < poll_limit) begin
         wb_read(addr_status, st);
         n++;
      end
      if (st !== 16'h0000) report_mismatch("status after transmit", 16'h0, st);
   endtask

   task automatic wait_status(input wb_data_t mask, output wb_data_t st);
      int n;
      n = 0;
      wb_read(addr_status, st);
      while ((st & mask) !== mask && n < poll_limit) begin
         wb_read(addr_status, st);
         n++;
      end
      if ((st & mask) !== mask) report_error("expected status bits never set");
   endtask

   // ********************
   // Directed tests.
   // ********************

   task automatic test_reset_state;
      int       errs;
      wb_data_t st;
      errs = error_count;
      if (tx !== 1'b1) report_mismatch("tx", 16'h1, tx);
      wb_read(addr_status, st);
      if (st !== 16'h0000) report_mismatch("status", 16'h0, st);
      finish_test("reset state", errs);
   endtask

   task automatic test_command_transmit;
      int  errs;
      time t_ack;
      time t_stop;
      errs = error_count;
      rng_state = xorshift32(rng_state);
      wb_write(addr_tx_cmd, rng_state[15:0], t_ack);
      capture_command(rng_state[15:0], t_stop);
      check_command_timing(t_ack, t_stop);
      wait_tx_idle();
      finish_test("command transmit", errs);
   endtask

   task automatic test_back_pressure;
      int       errs;
      cmd_t     cmd1;
      cmd_t     cmd2;
      time      t_ack;
      time      t_stop;
      wb_data_t st;
      errs = error_count;
      rng_state = xorshift32(rng_state);
      cmd1 = rng_state[15:0];
      rng_state = xorshift32(rng_state);
      cmd2 = rng_state[15:0];
      wb_write(addr_tx_cmd, cmd1, t_ack);
      fork
         capture_command(cmd1, t_stop);
         begin
            wb_read(addr_status, st);
            if (st !== 16'h0001) report_mismatch("status while busy", 16'h1, st);
            wb_write(addr_tx_cmd, cmd2, t_ack);
         end
      join
      // Last stop bit ends half a bit after its sample.
      if (t_ack <= t_stop + cpb / 2 * clk_period) begin
         report_error("second command acknowledged before the first one ended");
      end
      capture_command(cmd2, t_stop);
      check_command_timing(t_ack, t_stop);
      wait_tx_idle();
      wb_read(addr_tx_cmd, st);
      if (st !== cmd2) report_mismatch("tx_cmd read back", cmd2, st);
      finish_test("back-pressure", errs);
   endtask

   task automatic test_receive;
      int       errs;
      byte_t    b;
      wb_data_t st;
      errs = error_count;
      rng_state = xorshift32(rng_state);
      b = rng_state[7:0];
      send_frame(b, parity_bit(b), 1'b1);
      wait_status(16'h0002, st);
      if (st !== 16'h0002) report_mismatch("status after receive", 16'h2, st);
      wb_read(addr_rx_data, st);
      if (st !== {8'h00, b}) report_mismatch("rx_data", {8'h00, b}, st);
      wb_read(addr_status, st);
      if (st !== 16'h0000) report_mismatch("status after data read", 16'h0, st);
      finish_test("receive", errs);
   endtask

   task automatic test_receive_errors;
      int       errs;
      byte_t    b1;
      byte_t    b2;
      wb_data_t st;
      errs = error_count;
      rng_state = xorshift32(rng_state);
      b1 = rng_state[7:0];
      b2 = rng_state[15:8];
      send_frame(b1, ~parity_bit(b1), 1'b1);
      wait_status(16'h0004, st);
      if (st !== 16'h0006) report_mismatch("status after parity error", 16'h6, st);
      // Low stop bit, and no read since the last byte.
      send_frame(b2, parity_bit(b2), 1'b0);
      wait_status(16'h0008, st);
      if (st !== 16'h001e) report_mismatch("status after framing error", 16'h1e, st);
      wb_read(addr_rx_data, st);
      if (st !== {8'h00, b2}) report_mismatch("rx_data", {8'h00, b2}, st);
      wb_read(addr_status, st);
      if (st !== 16'h0000) report_mismatch("status after data read", 16'h0, st);
      finish_test("receive errors", errs);
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_dat_w    = '0;
      rx          = 1'b1;
      rng_state   = 32'h59c4;
      error_count = 0;
      test_count  = 0;
      fail_count  = 0;
      step_clocks(8);
      rst_n = 1'b1;
      test_reset_state();
      test_command_transmit();
      test_back_pressure();
      test_receive();
      test_receive_errors();
      $display("Tests: %0d run, %0d failed, %0d errors", test_count, fail_count, error_count);
      if (error_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
